// File: compile.f
verilog/opb_pkg.sv
verilog/adc16_pkg.sv
verilog/opb_addr_decode.sv
verilog/adc16_status_sync.sv
verilog/adc16_reg_file.sv
verilog/opb_adc16_controller.sv
test/opb_adc16_checker.sv
test/tb_opb_adc16_controller.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tb_opb_adc16_controller \
  -f compile.f -Mdir obj_dir -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 &&
cat sim.log &&
! grep -q "ERRORS FOUND" sim.log ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }

// File: test/tb_opb_adc16_controller.sv
// testbench for the OPB adc16 slave, window is 16 bytes at BASE
// inputs change 1 unit after the rising edge, outputs are sampled 1 unit after it
module tb_opb_adc16_controller;
  import adc16_pkg::*;

  localparam logic [31:0] BASE        = 32'h0001_0000;
  localparam logic [31:0] HIGH        = 32'h0001_000F;
  localparam int          ACK_TIMEOUT = 20;
  localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

  logic OPB_Clk, OPB_Rst, OPB_RNW, OPB_select, OPB_seqAddr;
  logic [0:31] OPB_ABus, OPB_DBus, Sl_DBus, adc16_delay_rst;
  logic [0:3]  OPB_BE;
  logic Sl_errAck, Sl_retry, Sl_toutSup, Sl_xferAck;
  logic adc0_csn1, adc0_csn2, adc0_csn3, adc0_csn4, adc0_sdata, adc0_sclk;
  logic adc1_csn1, adc1_csn2, adc1_csn3, adc1_csn4, adc1_sdata, adc1_sclk;
  logic adc16_reset, adc16_snap_req;
  logic [0:7] adc16_iserdes_bitslip;
  logic [0:4] adc16_delay_tap;
  logic [1:0] lock_in, rev_in;
  logic [3:0] units_in;

  // reference model state, OPB bit order
  logic [0:31] model_word [3];
  logic [31:0] lfsr_state;
  logic [0:31] rst_seen;
  logic [0:31] data;
  logic [0:3]  be;
  logic [1:0]  word;
  logic        last_rnw;
  int          errors, rst_high_cycles;
  logic [31:0] exp_q [$];
  string       name_q [$];

  opb_adc16_controller #(.C_BASEADDR(BASE), .C_HIGHADDR(HIGH), .SYNC_STAGES(2))
  opb_adc16_controller_inst (
    .OPB_Clk(OPB_Clk), .OPB_Rst(OPB_Rst), .OPB_ABus(OPB_ABus), .OPB_BE(OPB_BE),
    .OPB_DBus(OPB_DBus), .OPB_RNW(OPB_RNW), .OPB_select(OPB_select),
    .OPB_seqAddr(OPB_seqAddr), .Sl_DBus(Sl_DBus), .Sl_errAck(Sl_errAck),
    .Sl_retry(Sl_retry), .Sl_toutSup(Sl_toutSup), .Sl_xferAck(Sl_xferAck),
    .adc0_adc3wire_csn1(adc0_csn1), .adc0_adc3wire_csn2(adc0_csn2),
    .adc0_adc3wire_csn3(adc0_csn3), .adc0_adc3wire_csn4(adc0_csn4),
    .adc0_adc3wire_sdata(adc0_sdata), .adc0_adc3wire_sclk(adc0_sclk),
    .adc1_adc3wire_csn1(adc1_csn1), .adc1_adc3wire_csn2(adc1_csn2),
    .adc1_adc3wire_csn3(adc1_csn3), .adc1_adc3wire_csn4(adc1_csn4),
    .adc1_adc3wire_sdata(adc1_sdata), .adc1_adc3wire_sclk(adc1_sclk),
    .adc16_reset(adc16_reset), .adc16_iserdes_bitslip(adc16_iserdes_bitslip),
    .adc16_delay_rst(adc16_delay_rst), .adc16_delay_tap(adc16_delay_tap),
    .adc16_snap_req(adc16_snap_req), .adc16_locked(lock_in),
    .adc16_roach2_rev(rev_in), .adc16_num_units(units_in)
  );

  initial begin
    OPB_Clk = 1'b0;
    forever #5 OPB_Clk = ~OPB_Clk;
  end

  // galois step, one call per random bit
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ LFSR_TAPS;
    return n;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  // updates the model on writes, returns the expected read data
  function automatic logic [0:31] model_access(input logic rnw, input logic [1:0] w,
      input logic [0:31] wdata, input logic [0:3] wbe);
    logic [0:31] rd;
    rd = '0;
    if (w == 2'd3) return rd;
    if (!rnw) begin
      // each bit takes the new value when its byte lane is enabled
      for (int i = 0; i < 32; i++) begin
        if (wbe[i / 8]) model_word[w][i] = wdata[i];
      end
    end else if (w == 2'd0) begin
      rd[6:7]   = lock_in;
      rd[8:11]  = units_in;
      rd[14:15] = rev_in;
      rd[16:31] = model_word[0][16:31];
    end else begin
      rd = model_word[w];
    end
    return rd;
  endfunction

  task automatic check_equal(input string name, input logic [31:0] expected,
      input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("MISMATCH %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // pin groups against the model's field positions
  task automatic check_pins(input string name);
    check_equal({name, " 3wire"},
      32'({adc0_sclk, adc1_sclk, adc0_sdata, adc1_sdata,
           adc1_csn4, adc1_csn3, adc1_csn2, adc1_csn1,
           adc0_csn4, adc0_csn3, adc0_csn2, adc0_csn1}),
      32'({{2{model_word[0][ADC16_SCLK_BIT]}}, {2{model_word[0][ADC16_SDATA_BIT]}},
           ~model_word[0][24:31]}));
    check_equal({name, " ctrl"},
      32'({adc16_reset, adc16_snap_req, adc16_iserdes_bitslip, adc16_delay_tap}),
      32'({model_word[1][ADC16_RESET_BIT], model_word[1][ADC16_SNAP_BIT],
           model_word[1][16:23], model_word[1][27:31]}));
  endtask

  // one OPB transfer, select held until ack or timeout, then one idle cycle
  task automatic bus_xfer(input logic rnw, input logic [31:0] addr, input logic [0:31] wdata,
      input logic [0:3] wbe, input logic expect_ack);
    int   cycles;
    logic got_ack;
    cycles     = 0;
    got_ack    = 1'b0;
    last_rnw   = rnw;
    OPB_ABus   = addr;
    OPB_BE     = wbe;
    OPB_DBus   = wdata;
    OPB_RNW    = rnw;
    OPB_select = 1'b1;
    while (!got_ack && cycles < ACK_TIMEOUT) begin
      @(posedge OPB_Clk);
      #1;
      cycles++;
      got_ack = Sl_xferAck;
    end
    OPB_select = 1'b0;
    OPB_RNW    = 1'b0;
    OPB_DBus   = '0;
    OPB_BE     = '0;
    if (got_ack && expect_ack) begin
      check_equal("ack latency", 32'd2, 32'(cycles));
    end else if (got_ack) begin
      errors++;
      $display("slave acknowledged address %h outside its window", addr);
    end else if (expect_ack) begin
      errors++;
      $display("no ack from the slave within %0d cycles at address %h", ACK_TIMEOUT, addr);
    end
    @(posedge OPB_Clk);
    #1;
  endtask

  task automatic write_word(input logic [1:0] w, input logic [0:31] wdata,
      input logic [0:3] wbe);
    void'(model_access(1'b0, w, wdata, wbe));
    bus_xfer(1'b0, BASE + 32'(w) * 4, wdata, wbe, 1'b1);
  endtask

  task automatic read_word(input logic [1:0] w, input string name);
    exp_q.push_back(model_access(1'b1, w, '0, '0));
    name_q.push_back(name);
    bus_xfer(1'b1, BASE + 32'(w) * 4, '0, '0, 1'b1);
  endtask

  // compares read data in the ack cycle and tracks the strobe width
  always @(negedge OPB_Clk) begin
    if (|adc16_delay_rst) begin
      rst_high_cycles++;
      rst_seen = adc16_delay_rst;
    end
    if (Sl_xferAck && last_rnw) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("read acknowledged with no expected value queued");
      end else begin
        check_equal(name_q.pop_front(), exp_q.pop_front(), Sl_DBus);
      end
    end
  end

  initial begin
    OPB_Rst = 1'b1;
    OPB_ABus = '0;
    OPB_BE = '0;
    OPB_DBus = '0;
    OPB_RNW = 1'b0;
    OPB_select = 1'b0;
    OPB_seqAddr = 1'b0;
    lock_in = 2'b10;
    units_in = 4'd9;
    rev_in = 2'd3;
    last_rnw = 1'b0;
    errors = 0;
    rst_high_cycles = 0;
    rst_seen = '0;
    lfsr_state = 32'h07f4e217;
    for (int i = 0; i < 3; i++) model_word[i] = '0;
    repeat (10) @(posedge OPB_Clk);
    #1;
    OPB_Rst = 1'b0;

    // reset values
    check_pins("reset");
    check_equal("reset delay_rst", '0, adc16_delay_rst);
    check_equal("tied outputs", '0, 32'({Sl_errAck, Sl_retry, Sl_toutSup}));
    read_word(2'd1, "reset word 1");
    read_word(2'd2, "reset word 2");

    // random byte-enable writes to words 0 and 1
    for (int i = 0; i < 16; i++) begin
      word = 2'(rand_bits(1));
      data = rand_bits(32);
      be   = 4'(rand_bits(4));
      write_word(word, data, be);
      check_pins("random write");
      read_word(word, "random readback");
    end

    // strobe word, one pulse cycle carrying the merged word
    for (int i = 0; i < 4; i++) begin
      data = rand_bits(32);
      be   = 4'(rand_bits(4));
      rst_high_cycles = 0;
      write_word(ADC16_WORD_STROBE, data, be);
      check_equal("strobe cycles", (model_word[2] != '0) ? 32'd1 : 32'd0,
        32'(rst_high_cycles));
      if (model_word[2] != '0) check_equal("strobe value", model_word[2], rst_seen);
      check_equal("strobe idle", '0, adc16_delay_rst);
      read_word(ADC16_WORD_STROBE, "strobe readback");
    end

    // status inputs, allowed to settle through the synchroniser
    lock_in  = 2'b01;
    units_in = 4'd5;
    rev_in   = 2'd2;
    repeat (4) @(posedge OPB_Clk);
    #1;
    read_word(ADC16_WORD_3WIRE, "status word");

    // word 3 is inert
    write_word(2'd3, rand_bits(32), 4'hF);
    read_word(2'd3, "word 3");

    // outside the window, no ack and no register change
    bus_xfer(1'b0, HIGH + 32'd5, rand_bits(32), 4'hF, 1'b0);
    bus_xfer(1'b1, HIGH + 32'd1, '0, '0, 1'b0);
    check_pins("after out of range");
    for (int w = 0; w < 3; w++) read_word(2'(w), "after out of range");

    repeat (2) @(posedge OPB_Clk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected reads were never answered", exp_q.size());
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: test/opb_adc16_checker.sv
// concurrent checks on the OPB handshake and the delay reset strobe
// bound into opb_adc16_controller, all checks idle while OPB_Rst is high
module opb_adc16_checker (
  input logic                                    OPB_Clk,
  input logic                                    OPB_Rst,
  input logic                                    OPB_select,
  input logic                                    Sl_xferAck,
  input logic [0:opb_pkg::OPB_DWIDTH-1]          Sl_DBus,
  input logic [0:adc16_pkg::ADC16_NUM_DELAY_RST-1] adc16_delay_rst
);

  // one ack cycle per transfer
  ack_one_cycle: assert property (@(posedge OPB_Clk) disable iff (OPB_Rst)
    Sl_xferAck |=> !Sl_xferAck)
    else $error("xfer ack held for more than one cycle");

  // data bus must stay quiet outside the ack cycle
  dbus_quiet: assert property (@(posedge OPB_Clk) disable iff (OPB_Rst)
    !Sl_xferAck |-> (Sl_DBus == '0))
    else $error("slave data bus not zero without ack");

  // select sampled two edges before every ack
  ack_after_select: assert property (@(posedge OPB_Clk) disable iff (OPB_Rst)
    Sl_xferAck |-> $past(OPB_select, 2))
    else $error("xfer ack without a select two edges earlier");

  // delay reset is a single-cycle strobe
  strobe_width: assert property (@(posedge OPB_Clk) disable iff (OPB_Rst)
    (|adc16_delay_rst) |=> (adc16_delay_rst == '0))
    else $error("delay reset lines high two cycles in a row");

endmodule

bind opb_adc16_controller opb_adc16_checker opb_adc16_checker_inst (
  .OPB_Clk         (OPB_Clk),
  .OPB_Rst         (OPB_Rst),
  .OPB_select      (OPB_select),
  .Sl_xferAck      (Sl_xferAck),
  .Sl_DBus         (Sl_DBus),
  .adc16_delay_rst (adc16_delay_rst)
);

// File: verilog/opb_adc16_controller.sv
// OPB slave controlling a pair of adc16 boards
// ack comes two edges after select is first sampled, single transfers only
// OPB_seqAddr bursts are served as separate single transfers
// chip select pins are active low, register bits are active high
module opb_adc16_controller #(
  parameter logic [31:0] C_BASEADDR  = 32'h0000_0000,
  parameter logic [31:0] C_HIGHADDR  = 32'h0000_FFFF,
  parameter int          SYNC_STAGES = 2
) (
  input  logic                            OPB_Clk,
  input  logic                            OPB_Rst,
  input  logic [0:opb_pkg::OPB_DWIDTH-1]  OPB_ABus,
  input  logic [0:opb_pkg::OPB_NBYTES-1]  OPB_BE,
  input  logic [0:opb_pkg::OPB_DWIDTH-1]  OPB_DBus,
  input  logic                            OPB_RNW,
  input  logic                            OPB_select,
  input  logic                            OPB_seqAddr,
  output logic [0:opb_pkg::OPB_DWIDTH-1]  Sl_DBus,
  output logic                            Sl_errAck,
  output logic                            Sl_retry,
  output logic                            Sl_toutSup,
  output logic                            Sl_xferAck,

  output logic                            adc0_adc3wire_csn1,
  output logic                            adc0_adc3wire_csn2,
  output logic                            adc0_adc3wire_csn3,
  output logic                            adc0_adc3wire_csn4,
  output logic                            adc0_adc3wire_sdata,
  output logic                            adc0_adc3wire_sclk,
  output logic                            adc1_adc3wire_csn1,
  output logic                            adc1_adc3wire_csn2,
  output logic                            adc1_adc3wire_csn3,
  output logic                            adc1_adc3wire_csn4,
  output logic                            adc1_adc3wire_sdata,
  output logic                            adc1_adc3wire_sclk,

  output logic                            adc16_reset,
  output logic [0:7]                      adc16_iserdes_bitslip,
  output logic [0:adc16_pkg::ADC16_NUM_DELAY_RST-1] adc16_delay_rst,
  output logic [0:4]                      adc16_delay_tap,
  output logic                            adc16_snap_req,
  input  logic [1:0]                      adc16_locked,
  input  logic [1:0]                      adc16_roach2_rev,
  input  logic [3:0]                      adc16_num_units
);
  import opb_pkg::*;
  import adc16_pkg::*;

  opb_req_t        req;
  opb_rsp_t        rsp;
  adc16_ctrl_out_t ctrl;
  logic [1:0]      locked;

  // stage 1, address window and request register
  opb_addr_decode #(
    .C_BASEADDR (C_BASEADDR),
    .C_HIGHADDR (C_HIGHADDR)
  ) opb_addr_decode_inst (
    .OPB_Clk    (OPB_Clk),
    .reset      (OPB_Rst),
    .opb_abus   (OPB_ABus),
    .opb_be     (OPB_BE),
    .opb_dbus   (OPB_DBus),
    .opb_rnw    (OPB_RNW),
    .opb_select (OPB_select),
    .ack_seen   (rsp.ack),
    .req        (req)
  );

  // lock status comes from the ADC line clocks
  adc16_status_sync #(
    .SYNC_STAGES (SYNC_STAGES)
  ) adc16_status_sync_inst (
    .OPB_Clk      (OPB_Clk),
    .reset        (OPB_Rst),
    .locked_async (adc16_locked),
    .locked       (locked)
  );

  // stage 2, registers and response
  adc16_reg_file adc16_reg_file_inst (
    .OPB_Clk   (OPB_Clk),
    .reset     (OPB_Rst),
    .req       (req),
    .locked    (locked),
    .num_units (adc16_num_units),
    .board_rev (adc16_roach2_rev),
    .rsp       (rsp),
    .ctrl      (ctrl)
  );

  // bus response, read data is already zero outside the ack cycle
  assign Sl_xferAck = rsp.ack;
  assign Sl_DBus    = rsp.data;
  assign Sl_errAck  = 1'b0;
  assign Sl_retry   = 1'b0;
  assign Sl_toutSup = 1'b0;

  // shared serial clock and data to both boards
  assign adc0_adc3wire_sclk  = ctrl.sclk;
  assign adc1_adc3wire_sclk  = ctrl.sclk;
  assign adc0_adc3wire_sdata = ctrl.sdata;
  assign adc1_adc3wire_sdata = ctrl.sdata;

  // cs[0] is register bit 24, board 1 csn4
  assign adc1_adc3wire_csn4 = ~ctrl.cs[0];
  assign adc1_adc3wire_csn3 = ~ctrl.cs[1];
  assign adc1_adc3wire_csn2 = ~ctrl.cs[2];
  assign adc1_adc3wire_csn1 = ~ctrl.cs[3];
  assign adc0_adc3wire_csn4 = ~ctrl.cs[4];
  assign adc0_adc3wire_csn3 = ~ctrl.cs[5];
  assign adc0_adc3wire_csn2 = ~ctrl.cs[6];
  assign adc0_adc3wire_csn1 = ~ctrl.cs[7];

  // control word fields
  assign adc16_reset           = ctrl.adc_reset;
  assign adc16_snap_req        = ctrl.snap_req;
  assign adc16_iserdes_bitslip = ctrl.bitslip;
  assign adc16_delay_tap       = ctrl.delay_tap;
  assign adc16_delay_rst       = ctrl.delay_rst;

endmodule

// File: verilog/adc16_reg_file.sv
// adc16 register file, answers one request with one ack a cycle later
// word 2 is a strobe word, its outputs pulse for the ack cycle only
// status inputs must already be in the OPB_Clk domain
module adc16_reg_file (
  input  logic                      OPB_Clk,
  input  logic                      reset,
  input  opb_pkg::opb_req_t         req,
  input  logic [1:0]                locked,
  input  logic [3:0]                num_units,
  input  logic [1:0]                board_rev,
  output opb_pkg::opb_rsp_t         rsp,
  output adc16_pkg::adc16_ctrl_out_t ctrl
);
  import opb_pkg::*;
  import adc16_pkg::*;

  // stored words, OPB bit order
  logic [0:OPB_DWIDTH-1] reg_3wire;
  logic [0:OPB_DWIDTH-1] reg_ctrl;
  logic [0:OPB_DWIDTH-1] reg_strobe;
  // delay reset lines, high for one cycle after a word 2 write
  logic [0:OPB_DWIDTH-1] strobe_pulse;

  // current value of the addressed word and its merge with the write
  logic [0:OPB_DWIDTH-1] cur_word;
  logic [0:OPB_DWIDTH-1] merged_word;
  logic [0:OPB_DWIDTH-1] read_word;
  logic                  do_write;

  // byte lane merge, be[0] covers bits 0 to 7
  function automatic logic [0:OPB_DWIDTH-1] byte_merge(
    input logic [0:OPB_DWIDTH-1] old_word,
    input logic [0:OPB_DWIDTH-1] new_word,
    input logic [0:OPB_NBYTES-1] be
  );
    logic [0:OPB_DWIDTH-1] merged;
    merged = old_word;
    for (int b = 0; b < OPB_NBYTES; b++) begin
      if (be[b]) begin
        merged[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return merged;
  endfunction

  // pick the word that the byte enables are merged into
  always_comb begin
    case (req.word)
      ADC16_WORD_3WIRE:  cur_word = reg_3wire;
      ADC16_WORD_CTRL:   cur_word = reg_ctrl;
      ADC16_WORD_STROBE: cur_word = reg_strobe;
      default:           cur_word = '0;
    endcase
  end

  assign merged_word = byte_merge(cur_word, req.data, req.be);

  // word 3 is acked but never written
  assign do_write = req.valid && !req.rnw && req.in_range;

  // read mux
  always_comb begin
    read_word = '0;
    if (req.in_range) begin
      case (req.word)
        ADC16_WORD_3WIRE: begin
          // status fields plus the low half of the 3-wire word
          read_word[ADC16_LOCK_FIRST:ADC16_LOCK_LAST]   = locked;
          read_word[ADC16_UNITS_FIRST:ADC16_UNITS_LAST] = num_units;
          read_word[ADC16_REV_FIRST:ADC16_REV_LAST]     = board_rev;
          read_word[ADC16_W0_LOW_FIRST:OPB_DWIDTH-1]    =
            reg_3wire[ADC16_W0_LOW_FIRST:OPB_DWIDTH-1];
        end
        ADC16_WORD_CTRL:   read_word = reg_ctrl;
        ADC16_WORD_STROBE: read_word = reg_strobe;
        default:           read_word = '0;
      endcase
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      rsp.ack      <= 1'b0;
      rsp.data     <= '0;
      reg_3wire    <= '0;
      reg_ctrl     <= '0;
      reg_strobe   <= '0;
      strobe_pulse <= '0;
    end else begin
      // every issued request gets exactly one ack
      rsp.ack      <= req.valid;
      // read data follows every request, zero on writes and idle cycles
      rsp.data     <= (req.valid && req.rnw) ? read_word : '0;
      strobe_pulse <= '0;
      if (do_write) begin
        case (req.word)
          ADC16_WORD_3WIRE: reg_3wire <= merged_word;
          ADC16_WORD_CTRL:  reg_ctrl  <= merged_word;
          ADC16_WORD_STROBE: begin
            reg_strobe   <= merged_word;
            // pulse carries the merged word, not the raw bus data
            strobe_pulse <= merged_word;
          end
          default: ;
        endcase
      end
    end
  end

  // field extraction toward the pins
  assign ctrl.sclk      = reg_3wire[ADC16_SCLK_BIT];
  assign ctrl.sdata     = reg_3wire[ADC16_SDATA_BIT];
  assign ctrl.cs        = reg_3wire[ADC16_CS_FIRST:ADC16_CS_LAST];
  assign ctrl.adc_reset = reg_ctrl[ADC16_RESET_BIT];
  assign ctrl.snap_req  = reg_ctrl[ADC16_SNAP_BIT];
  assign ctrl.bitslip   = reg_ctrl[ADC16_BITSLIP_FIRST:ADC16_BITSLIP_LAST];
  assign ctrl.delay_tap = reg_ctrl[ADC16_TAP_FIRST:ADC16_TAP_LAST];
  assign ctrl.delay_rst = strobe_pulse;

endmodule

// File: verilog/adc16_status_sync.sv
// synchroniser for the two asynchronous clock-lock inputs
// each bit is synchronised on its own, no bus coherence between the bits
module adc16_status_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic       OPB_Clk,
  input  logic       reset,
  input  logic [1:0] locked_async,
  output logic [1:0] locked
);

  // flop chain, stage 0 takes the raw input
  logic [1:0] sync_q [SYNC_STAGES];

  always_ff @(posedge OPB_Clk) begin
    if (reset) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        sync_q[i] <= 2'b00;
      end
    end else begin
      sync_q[0] <= locked_async;
      // shift toward the last stage
      for (int i = 1; i < SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // last stage is safe to use in the OPB domain
  assign locked = sync_q[SYNC_STAGES-1];

endmodule

// File: verilog/opb_addr_decode.sv
// OPB request stage, one registered request per select
// the master must hold address, data and RNW until it sees the ack
// out-of-window addresses are dropped and never acknowledged
module opb_addr_decode #(
  parameter logic [31:0] C_BASEADDR = 32'h0000_0000,
  parameter logic [31:0] C_HIGHADDR = 32'h0000_FFFF
) (
  input  logic              OPB_Clk,
  input  logic              reset,
  input  logic [0:31]       opb_abus,
  input  logic [0:3]        opb_be,
  input  logic [0:31]       opb_dbus,
  input  logic              opb_rnw,
  input  logic              opb_select,
  input  logic              ack_seen,
  output opb_pkg::opb_req_t req
);
  import opb_pkg::*;

  // address as a plain number, same bit weights as the OPB bus
  logic [OPB_DWIDTH-1:0] addr;
  logic [OPB_DWIDTH-1:0] offset;
  logic [1:0]            word_idx;
  logic                  addr_match;
  // set from issue until the ack comes back
  logic                  busy;
  logic                  issue;

  assign addr = opb_abus;

  // window check on the full address
  assign addr_match = (addr >= C_BASEADDR) && (addr <= C_HIGHADDR);

  // word index is taken relative to the base
  assign offset   = addr - C_BASEADDR;
  assign word_idx = offset[3:2];

  // a held select is only issued once
  assign issue = opb_select && addr_match && !busy;

  always_ff @(posedge OPB_Clk) begin
    // payload is captured on issue only
    if (issue) begin
      req.rnw      <= opb_rnw;
      req.word     <= word_idx;
      req.in_range <= (word_idx != 2'd3);
      req.be       <= opb_be;
      req.data     <= opb_dbus;
    end
    if (reset) begin
      req.valid <= 1'b0;
      busy      <= 1'b0;
    end else begin
      // single-cycle request pulse
      req.valid <= issue;
      if (issue) begin
        busy <= 1'b1;
      end else if (ack_seen) begin
        // master drops select the cycle after the ack
        busy <= 1'b0;
      end
    end
  end

endmodule

// File: verilog/adc16_pkg.sv
// register map of the adc16 control slave
// bit positions are OPB numbering, bit 0 is the MSB of a 32-bit word
// words 0 to 2 are implemented, word 3 reads zero
package adc16_pkg;

  // word indices inside the address window
  localparam logic [1:0] ADC16_WORD_3WIRE  = 2'd0;
  localparam logic [1:0] ADC16_WORD_CTRL   = 2'd1;
  localparam logic [1:0] ADC16_WORD_STROBE = 2'd2;

  // word 0, 3-wire bus fields
  localparam int ADC16_SCLK_BIT      = 22;
  localparam int ADC16_SDATA_BIT     = 23;
  // bit 24 is board 1 csn4, bit 31 is board 0 csn1
  localparam int ADC16_CS_FIRST      = 24;
  localparam int ADC16_CS_LAST       = 31;

  // word 1, control fields
  localparam int ADC16_RESET_BIT     = 11;
  localparam int ADC16_SNAP_BIT      = 15;
  localparam int ADC16_BITSLIP_FIRST = 16;
  localparam int ADC16_BITSLIP_LAST  = 23;
  localparam int ADC16_TAP_FIRST     = 27;
  localparam int ADC16_TAP_LAST      = 31;

  // word 0 read-only status fields
  localparam int ADC16_LOCK_FIRST    = 6;
  localparam int ADC16_LOCK_LAST     = 7;
  localparam int ADC16_UNITS_FIRST   = 8;
  localparam int ADC16_UNITS_LAST    = 11;
  localparam int ADC16_REV_FIRST     = 14;
  localparam int ADC16_REV_LAST      = 15;
  // low half of the stored word 0 is echoed back on read
  localparam int ADC16_W0_LOW_FIRST  = 16;

  // one delay reset line per IDELAY group
  localparam int ADC16_NUM_DELAY_RST = 32;

  // control outputs toward the pins, chip selects still active high
  typedef struct packed {
    logic                             sclk;
    logic                             sdata;
    logic [0:7]                       cs;
    logic                             adc_reset;
    logic                             snap_req;
    logic [0:7]                       bitslip;
    logic [0:4]                       delay_tap;
    logic [0:ADC16_NUM_DELAY_RST-1]   delay_rst;
  } adc16_ctrl_out_t;

endpackage

// File: verilog/opb_pkg.sv
// bus-side types shared by the OPB slave stages
// data, byte enables and addresses use OPB bit order, bit 0 is the MSB
// one transfer in flight at a time, no bursts
package opb_pkg;

  // OPB data bus width and the byte lanes it carries
  localparam int OPB_DWIDTH = 32;
  localparam int OPB_NBYTES = OPB_DWIDTH / 8;

  // stage 1 output, one valid cycle per accepted transfer
  typedef struct packed {
    logic                     valid;
    logic                     rnw;
    // word index inside the slave's address window
    logic [1:0]               word;
    // high for words 0 to 2, word 3 is acked but inert
    logic                     in_range;
    logic [0:OPB_NBYTES-1]    be;
    logic [0:OPB_DWIDTH-1]    data;
  } opb_req_t;

  // stage 2 output, data is only meaningful with ack
  typedef struct packed {
    logic                     ack;
    logic [0:OPB_DWIDTH-1]    data;
  } opb_rsp_t;

endpackage
